/* Makefile */
TOP := apu_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard source/*.sv bench/*.sv)
	verilator --binary -j 0 --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f
	verilator --lint-only --top-module apu_top -f project.f

clean:
	rm -rf obj_dir $(LOG)

/* bench/apu_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_assert
	import apu_pkg::*;
(
	input logic                    apuv_4mhz,
	input logic                    rst_n,
	input logic                    rd,
	input logic                    rdata_valid,
	input logic                    power,
	input logic [7:0]              nr50,
	input logic [7:0]              nr51,
	input logic [NUM_CHANNELS-1:0] active
);

	int fail_count = 0;

	// ------------------------------------------------------------
	// read handshake
	// ------------------------------------------------------------
	a_valid_after_rd: assert property (
		@(posedge apuv_4mhz) disable iff (!rst_n) rd |=> rdata_valid
	) else begin
		fail_count++;
		$error("rdata_valid did not follow rd by one cycle");
	end

	a_no_stray_valid: assert property (
		@(posedge apuv_4mhz) disable iff (!rst_n) !rd |=> !rdata_valid
	) else begin
		fail_count++;
		$error("rdata_valid raised without a read one cycle before");
	end

	// ------------------------------------------------------------
	// power off state
	// ------------------------------------------------------------
	a_regs_clear_off: assert property (
		@(posedge apuv_4mhz) disable iff (!rst_n) !power |-> (nr50 == 8'h00 && nr51 == 8'h00)
	) else begin
		fail_count++;
		$error("NR50 or NR51 nonzero while power is off");
	end

	a_idle_when_off: assert property (
		@(posedge apuv_4mhz) disable iff (!rst_n) !power |-> (active == '0)
	) else begin
		fail_count++;
		$error("a channel is active while power is off");
	end

endmodule

`default_nettype wire

/* bench/apu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_checker
	import apu_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       exp_read,
	input  logic       exp_mix,
	input  logic [7:0] exp_rdata,
	input  mix_t       exp_left,
	input  mix_t       exp_right,
	input  logic [7:0] rdata,
	input  logic       rdata_valid,
	input  mix_t       left,
	input  mix_t       right,
	output int         checks,
	output int         errors,
	output int         pending
);

	logic [7:0] read_q[$];
	logic [7:0] want;
	int         check_cnt = 0;
	int         err_cnt = 0;
	int         pend_cnt = 0;

	assign checks  = check_cnt;
	assign errors  = err_cnt;
	assign pending = pend_cnt;

	// outputs change just after the rising edge, the falling edge sees them settled.
	always @(negedge clk) begin
		if (rst_n) begin
			if (exp_read) begin
				read_q.push_back(exp_rdata);
			end
			if (rdata_valid) begin
				if (read_q.size() == 0) begin
					$display("[%0t ns] rdata_valid came with no read outstanding", $time);
					err_cnt = err_cnt + 1;
				end else begin
					want = read_q.pop_front();
					check_cnt = check_cnt + 1;
					if (rdata !== want) begin
						$display("MISMATCH at %0t ns: rdata expected 0x%02h, got 0x%02h",
							$time, want, rdata);
						err_cnt = err_cnt + 1;
					end
				end
			end
			if (exp_mix) begin
				check_cnt = check_cnt + 2;
				if (left !== exp_left) begin
					$display("MISMATCH at %0t ns: left expected %0d, got %0d",
						$time, exp_left, left);
					err_cnt = err_cnt + 1;
				end
				if (right !== exp_right) begin
					$display("MISMATCH at %0t ns: right expected %0d, got %0d",
						$time, exp_right, right);
					err_cnt = err_cnt + 1;
				end
			end
			pend_cnt = read_q.size();
		end
	end

endmodule

`default_nettype wire

/* bench/apu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_tb
	import apu_pkg::*;
();

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_MIX,
		OP_TICK
	} op_e;

	typedef struct packed {
		op_e        op;
		logic [5:0] addr;
		logic [7:0] data;    // write data, or the expected read value.
		mix_t       left;
		mix_t       right;
		logic [7:0] idle;    // idle cycles after the step.
	} step_t;

	logic       clk;
	logic       rst_n;
	logic       wr;
	logic       rd;
	logic [5:0] addr;
	logic [7:0] wdata;
	logic       length_tick;
	logic [7:0] rdata;
	logic       rdata_valid;
	mix_t       left;
	mix_t       right;
	logic       exp_read;
	logic       exp_mix;
	logic [7:0] exp_rdata;
	mix_t       exp_left;
	mix_t       exp_right;
	int         checks;
	int         errors;
	int         pending;
	step_t      steps[$];
	int         watchdog_cycles = 0;

	tb_clock i_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	apu_top i_dut (
		.apuv_4mhz   (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.rd          (rd),
		.addr        (addr),
		.wdata       (wdata),
		.length_tick (length_tick),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.left        (left),
		.right       (right)
	);

	apu_checker i_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.exp_read    (exp_read),
		.exp_mix     (exp_mix),
		.exp_rdata   (exp_rdata),
		.exp_left    (exp_left),
		.exp_right   (exp_right),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.left        (left),
		.right       (right),
		.checks      (checks),
		.errors      (errors),
		.pending     (pending)
	);

	bind apu_control apu_assert i_assert (
		.apuv_4mhz   (apuv_4mhz),
		.rst_n       (rst_n),
		.rd          (rd),
		.rdata_valid (rdata_valid),
		.power       (power),
		.nr50        (nr50),
		.nr51        (nr51),
		.active      (active)
	);

	// ------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------
	function automatic logic [5:0] chan_reg(input int n, input chan_field_e f);
		return 6'(32'h10 + 4 * n + int'(f));    // channel n block starts at 0x10 + 4n.
	endfunction

	function automatic void add_step(input op_e op, input logic [5:0] a, input logic [7:0] d,
		input mix_t l, input mix_t r, input int idle);
		steps.push_back('{op, a, d, l, r, 8'(idle)});
	endfunction

	function automatic void add_write(input logic [5:0] a, input logic [7:0] d, input int idle);
		add_step(OP_WRITE, a, d, '0, '0, idle);
	endfunction

	function automatic void add_read(input logic [5:0] a, input logic [7:0] exp, input int idle);
		add_step(OP_READ, a, exp, '0, '0, idle);
	endfunction

	function automatic void add_mix_check(input int l, input int r, input int idle);
		add_step(OP_MIX, 6'h00, 8'h00, mix_t'(l), mix_t'(r), idle);
	endfunction

	function automatic void add_tick(input int idle);
		add_step(OP_TICK, 6'h00, 8'h00, '0, '0, idle);
	endfunction

	function automatic void build_table();
		add_mix_check(0, 0, 0);
		add_read(REG_NR52, 8'h70, 1);    // with power off and no channel active only the fixed ones show.
		add_write(REG_NR50, 8'h77, 0);    // dropped while power is off.
		add_read(REG_NR50, 8'h00, 1);
		add_write(REG_NR52, 8'h80, 0);
		add_write(REG_NR50, 8'h31, 0);
		add_write(REG_NR51, 8'h11, 0);
		add_read(REG_NR52, 8'hF0, 0);
		add_read(REG_NR50, 8'h31, 0);
		add_read(REG_NR51, 8'h11, 0);
		add_read(chan_reg(0, FLD_LENGTH), 8'hFF, 0);
		add_read(chan_reg(3, FLD_CONTROL), 8'hFF, 0);
		add_read(6'h30, 8'hFF, 1);
		add_write(chan_reg(0, FLD_VOLUME), 8'h05, 0);
		add_write(chan_reg(0, FLD_PERIOD), 8'h00, 0);
		add_write(chan_reg(2, FLD_VOLUME), 8'h0A, 0);
		add_write(chan_reg(0, FLD_CONTROL), 8'h80, 2);
		// only channel 0 is routed; left gain is 3 + 1 and right gain is 1 + 1.
		add_mix_check(5 * 4, 5 * 2, 0);
		add_write(chan_reg(2, FLD_CONTROL), 8'h80, 1);
		add_read(REG_NR52, 8'hF5, 1);
		add_mix_check(5 * 4, 5 * 2, 0);
		// channel 1 gets a length of 64 - 62 = 2 ticks.
		add_write(chan_reg(1, FLD_VOLUME), 8'h0F, 0);
		add_write(chan_reg(1, FLD_LENGTH), 8'h3E, 0);
		add_write(chan_reg(1, FLD_CONTROL), 8'hC0, 1);
		add_read(REG_NR52, 8'hF7, 1);
		add_tick(1);
		add_read(REG_NR52, 8'hF7, 1);
		// the status bit must already be low in the cycle after the last tick.
		add_tick(0);
		add_read(REG_NR52, 8'hF5, 1);
		add_write(chan_reg(2, FLD_VOLUME), 8'h00, 0);
		add_read(REG_NR52, 8'hF1, 1);
		add_mix_check(5 * 4, 5 * 2, 0);
		add_write(REG_NR52, 8'h00, 2);
		add_read(REG_NR52, 8'h70, 0);
		add_read(REG_NR50, 8'h00, 0);
		add_read(REG_NR51, 8'h00, 2);
		add_mix_check(0, 0, 0);
	endfunction

	// ------------------------------------------------------------
	// driving
	// ------------------------------------------------------------
	task automatic apply_step(input step_t s);
		wr          <= (s.op == OP_WRITE);
		rd          <= (s.op == OP_READ);
		length_tick <= (s.op == OP_TICK);
		exp_read    <= (s.op == OP_READ);
		exp_mix     <= (s.op == OP_MIX);
		addr        <= s.addr;
		wdata       <= s.data;
		exp_rdata   <= s.data;
		exp_left    <= s.left;
		exp_right   <= s.right;
	endtask

	task automatic drive_idle();
		wr          <= 1'b0;
		rd          <= 1'b0;
		length_tick <= 1'b0;
		exp_read    <= 1'b0;
		exp_mix     <= 1'b0;
	endtask

	initial begin
		int cycles;
		int assert_fails;
		int total;
		wr          = 1'b0;
		rd          = 1'b0;
		addr        = 6'h00;
		wdata       = 8'h00;
		length_tick = 1'b0;
		exp_read    = 1'b0;
		exp_mix     = 1'b0;
		exp_rdata   = 8'h00;
		exp_left    = '0;
		exp_right   = '0;
		build_table();
		cycles = 3 + 5 + 50;    // reset, the closing drain and a margin.
		foreach (steps[i]) begin
			cycles = cycles + 1 + int'(steps[i].idle);
		end
		watchdog_cycles = cycles;
		wait (rst_n === 1'b1);
		foreach (steps[i]) begin
			@(posedge clk);
			apply_step(steps[i]);
			repeat (steps[i].idle) begin
				@(posedge clk);
				drive_idle();
			end
		end
		@(posedge clk);
		drive_idle();
		repeat (4) @(posedge clk);
		assert_fails = i_dut.i_control.i_assert.fail_count;
		if (pending != 0) begin
			$display("%0d register reads never got rdata_valid back", pending);
		end
		total = errors + assert_fails + pending;
		$display("checks: %0d, mismatches: %0d, assertion failures: %0d, lost reads: %0d",
			checks, errors, assert_fails, pending);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the stimulus table did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;    // 40 ns period, the 4 MHz unit clock scaled down.
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* project.f */
source/apu_pkg.sv
source/chan_ctrl_if.sv
source/apu_control.sv
source/tone_channel.sv
source/apu_mixer.sv
source/apu_top.sv
bench/tb_clock.sv
bench/apu_assert.sv
bench/apu_checker.sv
bench/apu_tb.sv

/* source/apu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_control
	import apu_pkg::*;
(
	input  logic                    apuv_4mhz,
	input  logic                    rst_n,
	input  logic                    wr,
	input  logic                    rd,
	input  logic [5:0]              addr,
	input  logic [7:0]              wdata,
	input  logic                    length_tick,
	input  logic [NUM_CHANNELS-1:0] active,
	output logic [7:0]              rdata,
	output logic                    rdata_valid,
	output logic [7:0]              nr50,
	output logic [7:0]              nr51,
	chan_ctrl_if.ctrl               chans
);

	logic       power;
	logic [1:0] div;
	logic       tick_2mhz;
	logic       nr52_wr;
	logic       power_off_wr;
	logic       reg_wr;
	logic       ch_hit;
	logic [7:0] rd_mux;

	// ------------------------------------------------------------
	// power and clock enables
	// ------------------------------------------------------------
	assign nr52_wr      = wr && (addr == REG_NR52);
	assign power_off_wr = nr52_wr && !wdata[7];

	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			power <= 1'b0;
		end else if (nr52_wr) begin
			power <= wdata[7];    // only bit 7 of NR52 is writable.
		end
	end

	// the divider is held while the unit is off so the enables restart in phase.
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			div <= 2'd0;
		end else if (!power) begin
			div <= 2'd0;
		end else begin
			div <= div + 2'd1;
		end
	end

	assign tick_2mhz = power && div[0];
	assign chans.tick_1mhz   = tick_2mhz && div[1];
	assign chans.length_tick = length_tick;
	// channels clear at the same edge that turns power off.
	assign chans.power       = power && !power_off_wr;

	// ------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------
	assign reg_wr = wr && power;    // everything except NR52 needs power.

	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			nr50 <= 8'h00;
			nr51 <= 8'h00;
		end else if (power_off_wr) begin
			nr50 <= 8'h00;
			nr51 <= 8'h00;
		end else if (reg_wr) begin
			if (addr == REG_NR50) nr50 <= wdata;
			if (addr == REG_NR51) nr51 <= wdata;
		end
	end

	// channel writes go out undecoded, each channel matches sel itself.
	assign ch_hit = (addr >= REG_CH_FIRST) && (addr <= REG_CH_LAST);

	assign chans.wr    = reg_wr && ch_hit;
	assign chans.sel   = chan_sel_t'(addr[3:2]);
	assign chans.field = chan_field_e'(addr[1:0]);
	assign chans.wdata = wdata;

	// ------------------------------------------------------------
	// register reads
	// ------------------------------------------------------------
	always_comb begin
		case (addr)
			REG_NR50: rd_mux = nr50;
			REG_NR51: rd_mux = nr51;
			REG_NR52: rd_mux = {power, 3'b111, active};
			default:  rd_mux = READ_UNMAPPED;
		endcase
	end

	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= rd;    // exactly one cycle behind the strobe.
		end
	end

	always_ff @(posedge apuv_4mhz) begin
		if (rd) begin
			rdata <= rd_mux;
		end
	end

endmodule

`default_nettype wire

/* source/apu_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_mixer
	import apu_pkg::*;
(
	input  logic                     apuv_4mhz,
	input  logic                     rst_n,
	input  sample_t [NUM_CHANNELS-1:0] samples,
	input  logic [NUM_CHANNELS-1:0]  active,
	input  logic [7:0]               nr50,
	input  logic [7:0]               nr51,
	output mix_t                     left,
	output mix_t                     right
);

	mix_t sum_l;
	mix_t sum_r;
	mix_t gain_l;
	mix_t gain_r;

	// NR51 upper nibble routes channels to the left, lower nibble to the right.
	always_comb begin
		sum_l = '0;
		sum_r = '0;
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			if (active[n] && nr51[4+n]) begin
				sum_l = sum_l + mix_t'(samples[n]);
			end
			if (active[n] && nr51[n]) begin
				sum_r = sum_r + mix_t'(samples[n]);
			end
		end
	end

	// master volume 0..7 scales by 1..8. The Vin bits are not used.
	assign gain_l = mix_t'(nr50[6:4]) + mix_t'(1);
	assign gain_r = mix_t'(nr50[2:0]) + mix_t'(1);

	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			left  <= '0;
			right <= '0;
		end else begin
			left  <= sum_l * gain_l;    // at most 60 * 8, fits in nine bits.
			right <= sum_r * gain_r;
		end
	end

endmodule

`default_nettype wire

/* source/apu_pkg.sv */
`default_nettype none

package apu_pkg;

	// ------------------------------------------------------------
	// channel count and widths
	// ------------------------------------------------------------
	localparam int NUM_CHANNELS = 4;
	localparam int CHAN_SEL_W   = $clog2(NUM_CHANNELS);

	typedef logic [CHAN_SEL_W-1:0] chan_sel_t;
	typedef logic [3:0]            sample_t;    // one channel sample, 0 to 15.
	typedef logic [8:0]            mix_t;       // up to 4 * 15 * 8 = 480.

	// write-only and unmapped offsets read back as all ones.
	localparam logic [7:0] READ_UNMAPPED = 8'hFF;

	// ------------------------------------------------------------
	// register map
	// ------------------------------------------------------------
	// channel n, field f sits at 0x10 + 4*n + f.
	typedef enum logic [5:0] {
		REG_CH_FIRST = 6'h10,
		REG_CH_LAST  = 6'h1F,
		REG_NR50     = 6'h24,    // master volume.
		REG_NR51     = 6'h25,    // panning.
		REG_NR52     = 6'h26     // power and status.
	} apu_reg_e;

	// low two address bits inside a channel block.
	typedef enum logic [1:0] {
		FLD_LENGTH  = 2'd0,
		FLD_VOLUME  = 2'd1,
		FLD_PERIOD  = 2'd2,
		FLD_CONTROL = 2'd3
	} chan_field_e;

endpackage

`default_nettype wire

/* source/apu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_top
	import apu_pkg::*;
(
	input  logic       apuv_4mhz,
	input  logic       rst_n,
	input  logic       wr,
	input  logic       rd,
	input  logic [5:0] addr,
	input  logic [7:0] wdata,
	input  logic       length_tick,
	output logic [7:0] rdata,
	output logic       rdata_valid,
	output mix_t       left,
	output mix_t       right
);

	chan_ctrl_if chans ();

	sample_t [NUM_CHANNELS-1:0] samples;
	logic [NUM_CHANNELS-1:0]    active;
	logic [7:0]                 nr50;
	logic [7:0]                 nr51;

	apu_control i_control (
		.apuv_4mhz   (apuv_4mhz),
		.rst_n       (rst_n),
		.wr          (wr),
		.rd          (rd),
		.addr        (addr),
		.wdata       (wdata),
		.length_tick (length_tick),
		.active      (active),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.nr50        (nr50),
		.nr51        (nr51),
		.chans       (chans)
	);

	// ------------------------------------------------------------
	// tone channels, all on the same write bus
	// ------------------------------------------------------------
	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
		tone_channel #(
			.CHAN_IDX (i)
		) i_chan (
			.apuv_4mhz (apuv_4mhz),
			.rst_n     (rst_n),
			.ctrl      (chans),
			.sample    (samples[i]),
			.active    (active[i])
		);
	end

	apu_mixer i_mixer (
		.apuv_4mhz (apuv_4mhz),
		.rst_n     (rst_n),
		.samples   (samples),
		.active    (active),
		.nr50      (nr50),
		.nr51      (nr51),
		.left      (left),
		.right     (right)
	);

endmodule

`default_nettype wire

/* source/chan_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Register writes and timing strobes fanned out from the control block to every
// tone channel. Each channel picks out its own writes by comparing sel.
interface chan_ctrl_if
	import apu_pkg::*;
();

	logic        wr;             // one-cycle write strobe, already power gated.
	chan_sel_t   sel;
	chan_field_e field;
	logic [7:0]  wdata;
	logic        tick_1mhz;      // one cycle in four.
	logic        length_tick;    // forwarded 128 Hz strobe.
	logic        power;

	modport ctrl (
		output wr, sel, field, wdata,
		output tick_1mhz, length_tick, power
	);

	modport chan (
		input wr, sel, field, wdata,
		input tick_1mhz, length_tick, power
	);

endinterface

`default_nettype wire

/* source/tone_channel.sv */
`timescale 1ns/1ps
`default_nettype none

// One square-wave channel. The half period is (256 - period) ticks of the 1 MHz
// enable, so period 0 gives 256 us high and 256 us low.
module tone_channel
	import apu_pkg::*;
#(
	parameter int unsigned CHAN_IDX = 0
) (
	input  logic      apuv_4mhz,
	input  logic      rst_n,
	chan_ctrl_if.chan ctrl,
	output sample_t   sample,
	output logic      active
);

	logic       hit;
	logic       trigger;
	logic       vol_zero_wr;
	logic [3:0] volume;
	logic [7:0] period;
	logic       len_en;
	logic [6:0] len_cnt;
	logic       len_step;
	logic       len_expire;
	logic [8:0] div_cnt;
	logic [8:0] half_period;
	logic       phase;

	assign hit         = ctrl.wr && (ctrl.sel == chan_sel_t'(CHAN_IDX));
	assign trigger     = hit && (ctrl.field == FLD_CONTROL) && ctrl.wdata[7];
	assign vol_zero_wr = hit && (ctrl.field == FLD_VOLUME) && (ctrl.wdata[3:0] == 4'd0);
	assign half_period = 9'd256 - {1'b0, period};

	// ------------------------------------------------------------
	// channel registers
	// ------------------------------------------------------------
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			volume <= 4'd0;
			period <= 8'd0;
			len_en <= 1'b0;
		end else if (!ctrl.power) begin
			volume <= 4'd0;
			period <= 8'd0;
			len_en <= 1'b0;
		end else if (hit) begin
			case (ctrl.field)
				FLD_VOLUME:  volume <= ctrl.wdata[3:0];
				FLD_PERIOD:  period <= ctrl.wdata;
				FLD_CONTROL: len_en <= ctrl.wdata[6];
				default:     ;    // the length field loads the counter below.
			endcase
		end
	end

	// ------------------------------------------------------------
	// length counter
	// ------------------------------------------------------------
	assign len_step   = len_en && ctrl.length_tick && (len_cnt != 7'd0);
	assign len_expire = len_step && (len_cnt == 7'd1);

	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			len_cnt <= 7'd0;
		end else if (!ctrl.power) begin
			len_cnt <= 7'd0;
		end else if (hit && (ctrl.field == FLD_LENGTH)) begin
			len_cnt <= 7'd64 - {1'b0, ctrl.wdata[5:0]};
		end else if (trigger && (len_cnt == 7'd0)) begin
			len_cnt <= 7'd64;    // an expired counter restarts at full length.
		end else if (len_step) begin
			len_cnt <= len_cnt - 7'd1;
		end
	end

	// a trigger only starts the channel if its volume is nonzero.
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else if (!ctrl.power || vol_zero_wr) begin
			active <= 1'b0;
		end else if (trigger) begin
			active <= (volume != 4'd0);
		end else if (len_expire) begin
			active <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// period divider and output
	// ------------------------------------------------------------
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= 9'd0;
			phase   <= 1'b0;
		end else if (!ctrl.power) begin
			div_cnt <= 9'd0;
			phase   <= 1'b0;
		end else if (trigger) begin
			div_cnt <= half_period;
			phase   <= 1'b1;    // every note starts on the high half.
		end else if (ctrl.tick_1mhz && active) begin
			if (div_cnt <= 9'd1) begin
				div_cnt <= half_period;
				phase   <= !phase;
			end else begin
				div_cnt <= div_cnt - 9'd1;
			end
		end
	end

	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			sample <= '0;
		end else begin
			sample <= (active && phase) ? volume : '0;
		end
	end

endmodule

`default_nettype wire
